// File: compile.f
+incdir+include
logic/cachePkg.sv
logic/dataCache.sv
logic/storeAlign.sv
logic/backingMemory.sv
logic/memAccessUnit.sv
logic/memSubsystem.sv
tb/tbMemSubsystem.sv

// File: include/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address width seen by the pipeline.
`define ADDR_W 64

// number of cache sets. The set index sits just above the doubleword offset.
`define SETS 4

// backing store depth in doublewords, so byte addresses stay below 512.
`define MEM_WORDS 64

// cycles from a memory read strobe to the read data pulse.
`define MEM_LATENCY 3

`endif

// File: logic/backingMemory.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module backingMemory (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          memRead,
    input  logic [`ADDR_W-1:0]            memAddr,
    input  logic                          memWrite,
    input  logic [cachePkg::DATA_W-1:0]   memWdata,
    input  logic [cachePkg::MASK_W-1:0]   memMask,
    output logic                          memValid,
    output logic [cachePkg::DATA_W-1:0]   memRdata
);
    import cachePkg::*;

    // the last latency cycle is the output register itself.
    localparam int DEPTH = `MEM_LATENCY - 1;

    logic [DATA_W-1:0]    memArr [`MEM_WORDS];
    logic [MEM_IDX_W-1:0] wordIdx;
    logic [DEPTH-1:0]     pendValid;
    logic [MEM_IDX_W-1:0] pendIdx [DEPTH];

    assign wordIdx = memAddr[OFFSET_W +: MEM_IDX_W];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (memMask[b]) begin
                    memArr[wordIdx][8*b +: 8] <= memWdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pendValid <= '0;
            memValid <= 1'b0;
        end else begin
            pendValid[0] <= memRead;
            for (int i = 1; i < DEPTH; i++) begin
                pendValid[i] <= pendValid[i-1];
            end
            memValid <= pendValid[DEPTH-1];
        end
    end

    // read data is held until the next read completes.
    always_ff @(posedge clk) begin
        pendIdx[0] <= wordIdx;
        for (int i = 1; i < DEPTH; i++) begin
            pendIdx[i] <= pendIdx[i-1];
        end
        if (pendValid[DEPTH-1]) begin
            memRdata <= memArr[pendIdx[DEPTH-1]];
        end
    end

    addrInRange: assert property (@(posedge clk) disable iff (rst)
        (memRead || memWrite) |-> memAddr[`ADDR_W-1:OFFSET_W] < `MEM_WORDS)
        else $error("backingMemory: address %h beyond memory", memAddr);

endmodule

// File: logic/cachePkg.sv
`include "cache_defs.svh"

package cachePkg;

    // access sizes in the order of the funct3 low bits.
    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W,
        SIZE_D
    } accessSize_t;

    localparam int DATA_W = 64;
    localparam int MASK_W = DATA_W / 8;

    // byte offset within a line, then set index, then tag.
    localparam int OFFSET_W = $clog2(MASK_W);
    localparam int INDEX_W = $clog2(`SETS);
    localparam int TAG_W = `ADDR_W - INDEX_W - OFFSET_W;

    localparam int MEM_IDX_W = $clog2(`MEM_WORDS);

endpackage

// File: logic/dataCache.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module dataCache (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`ADDR_W-1:0]            lookupAddr,
    output logic                          hit,
    output logic [cachePkg::DATA_W-1:0]   hitData,
    input  logic                          fill,
    input  logic [`ADDR_W-1:0]            fillAddr,
    input  logic [cachePkg::DATA_W-1:0]   fillData,
    input  logic                          update,
    input  logic [`ADDR_W-1:0]            updateAddr,
    input  logic [cachePkg::DATA_W-1:0]   updateData,
    input  logic [cachePkg::MASK_W-1:0]   updateMask
);
    import cachePkg::*;

    localparam int WAYS = 2;

    logic [WAYS-1:0]   validArr [`SETS];
    logic [TAG_W-1:0]  tagArr [WAYS][`SETS];
    logic [DATA_W-1:0] dataArr [WAYS][`SETS];

    // one bit per set naming the way the next fill replaces.
    logic [`SETS-1:0]  victim;

    logic [INDEX_W-1:0] lookupSet;
    logic [INDEX_W-1:0] fillSet;
    logic [INDEX_W-1:0] updateSet;
    logic [TAG_W-1:0]   lookupTag;
    logic [TAG_W-1:0]   fillTag;
    logic [TAG_W-1:0]   updateTag;
    logic [WAYS-1:0]    lookupMatch;
    logic [WAYS-1:0]    updateMatch;
    logic               fillWay;

    function automatic logic [DATA_W-1:0] mergeBytes(
        input logic [DATA_W-1:0] oldWord,
        input logic [DATA_W-1:0] newWord,
        input logic [MASK_W-1:0] mask
    );
        logic [DATA_W-1:0] merged;
        merged = oldWord;
        for (int b = 0; b < MASK_W; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign lookupSet = lookupAddr[OFFSET_W +: INDEX_W];
    assign lookupTag = lookupAddr[OFFSET_W + INDEX_W +: TAG_W];
    assign fillSet = fillAddr[OFFSET_W +: INDEX_W];
    assign fillTag = fillAddr[OFFSET_W + INDEX_W +: TAG_W];
    assign updateSet = updateAddr[OFFSET_W +: INDEX_W];
    assign updateTag = updateAddr[OFFSET_W + INDEX_W +: TAG_W];

    assign fillWay = victim[fillSet];

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            lookupMatch[w] = validArr[lookupSet][w] && (tagArr[w][lookupSet] == lookupTag);
            updateMatch[w] = validArr[updateSet][w] && (tagArr[w][updateSet] == updateTag);
        end
    end

    assign hit = |lookupMatch;

    always_comb begin
        if (lookupMatch[0]) begin
            hitData = dataArr[0][lookupSet];
        end else if (lookupMatch[1]) begin
            hitData = dataArr[1][lookupSet];
        end else begin
            hitData = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `SETS; s++) begin
                validArr[s] <= '0;
            end
            victim <= '0;
        end else if (fill) begin
            validArr[fillSet][fillWay] <= 1'b1;
            victim[fillSet] <= ~victim[fillSet];
        end
    end

    // a store that misses leaves the arrays alone. There is no write-allocate.
    always_ff @(posedge clk) begin
        if (fill) begin
            tagArr[fillWay][fillSet] <= fillTag;
            dataArr[fillWay][fillSet] <= fillData;
        end else if (update) begin
            for (int w = 0; w < WAYS; w++) begin
                if (updateMatch[w]) begin
                    dataArr[w][updateSet] <= mergeBytes(dataArr[w][updateSet],
                                                        updateData, updateMask);
                end
            end
        end
    end

    fillUpdateExclusive: assert property (@(posedge clk) disable iff (rst)
        !(fill && update))
        else $error("dataCache: fill and update in the same cycle");

    // a line lives in at most one way of its set.
    singleWayHit: assert property (@(posedge clk) disable iff (rst)
        !(&lookupMatch) && !(&updateMatch))
        else $error("dataCache: both ways hit on one address");

endmodule

// File: logic/memAccessUnit.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module memAccessUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    loadReq,
    input  logic                    storeReq,
    input  logic [`ADDR_W-1:0]      addr,
    input  cachePkg::accessSize_t   size,
    output logic                    busy,
    output logic                    loadDone,
    output logic                    loadHit,
    output logic                    storeDone,
    output logic [`ADDR_W-1:0]      lookupAddr,
    input  logic                    hit,
    output logic                    fill,
    output logic [`ADDR_W-1:0]      fillAddr,
    output logic                    update,
    output logic [`ADDR_W-1:0]      updateAddr,
    output logic                    memRead,
    output logic [`ADDR_W-1:0]      memAddr,
    output logic                    memWrite,
    input  logic                    memValid,
    output logic                    useMem,
    output cachePkg::accessSize_t   alignSize
);
    import cachePkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT,
        RESPOND
    } unitState_t;

    unitState_t     state;
    logic [`ADDR_W-1:0] reqAddr;
    accessSize_t    reqSize;
    logic           loadGo;
    logic           storeGo;

    assign loadGo = loadReq && (state == IDLE);
    assign storeGo = storeReq && (state == IDLE);
    assign busy = (state != IDLE);

    // stores complete in the cycle they are presented and never leave idle.
    assign memWrite = storeGo;
    assign update = storeGo;
    assign updateAddr = addr;

    assign lookupAddr = reqAddr;
    assign fillAddr = reqAddr;
    assign memRead = (state == LOOKUP) && !hit;
    assign fill = (state == RESPOND);

    // the aligner follows the store in flight, otherwise the latched load.
    assign memAddr = storeGo ? addr : reqAddr;
    assign alignSize = storeGo ? size : reqSize;

    always_ff @(posedge clk) begin
        if (loadGo) begin
            reqAddr <= addr;
            reqSize <= size;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            loadDone <= 1'b0;
            loadHit <= 1'b0;
            storeDone <= 1'b0;
            useMem <= 1'b0;
        end else begin
            loadDone <= 1'b0;
            storeDone <= storeGo;
            case (state)
                IDLE: begin
                    if (loadReq) begin
                        useMem <= 1'b0;
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        loadDone <= 1'b1;
                        loadHit <= 1'b1;
                        state <= IDLE;
                    end else begin
                        useMem <= 1'b1;
                        state <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (memValid) begin
                        state <= RESPOND;
                    end
                end
                default: begin
                    // line is written this cycle and the result goes out next.
                    loadDone <= 1'b1;
                    loadHit <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    noReqWhileBusy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !(loadReq || storeReq))
        else $error("memAccessUnit: request while busy");

    oneStrobe: assert property (@(posedge clk) disable iff (rst)
        !(loadReq && storeReq))
        else $error("memAccessUnit: load and store strobes together");

    // the miss path counts on the memory answering after a fixed delay.
    readLatency: assert property (@(posedge clk) disable iff (rst)
        memRead |-> ##(`MEM_LATENCY) memValid)
        else $error("memAccessUnit: memory data not back on time");

endmodule

// File: logic/memSubsystem.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module memSubsystem (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          loadReq,
    input  logic                          storeReq,
    input  logic [`ADDR_W-1:0]            addr,
    input  cachePkg::accessSize_t         size,
    input  logic [cachePkg::DATA_W-1:0]   storeData,
    output logic                          loadDone,
    output logic                          loadHit,
    output logic [cachePkg::DATA_W-1:0]   loadData,
    output logic                          storeDone,
    output logic                          busy
);
    import cachePkg::*;

    logic [`ADDR_W-1:0] lookupAddr;
    logic [`ADDR_W-1:0] fillAddr;
    logic [`ADDR_W-1:0] updateAddr;
    logic [`ADDR_W-1:0] memAddr;
    logic               hit;
    logic               fill;
    logic               update;
    logic               memRead;
    logic               memWrite;
    logic               memValid;
    logic               useMem;
    accessSize_t        alignSize;
    logic [DATA_W-1:0]  hitData;
    logic [DATA_W-1:0]  memRdata;
    logic [DATA_W-1:0]  loadWord;
    logic [DATA_W-1:0]  alignedData;
    logic [MASK_W-1:0]  byteMask;

    // after a miss the result comes from the word just read.
    assign loadWord = useMem ? memRdata : hitData;

    memAccessUnit accessUnit (
        .clk(clk), .rst(rst),
        .loadReq(loadReq), .storeReq(storeReq), .addr(addr), .size(size),
        .busy(busy), .loadDone(loadDone), .loadHit(loadHit), .storeDone(storeDone),
        .lookupAddr(lookupAddr), .hit(hit),
        .fill(fill), .fillAddr(fillAddr), .update(update), .updateAddr(updateAddr),
        .memRead(memRead), .memAddr(memAddr), .memWrite(memWrite), .memValid(memValid),
        .useMem(useMem), .alignSize(alignSize)
    );

    storeAlign aligner (
        .addr(memAddr), .size(alignSize), .storeData(storeData), .loadWord(loadWord),
        .alignedData(alignedData), .byteMask(byteMask), .loadResult(loadData)
    );

    dataCache cache (
        .clk(clk), .rst(rst),
        .lookupAddr(lookupAddr), .hit(hit), .hitData(hitData),
        .fill(fill), .fillAddr(fillAddr), .fillData(memRdata),
        .update(update), .updateAddr(updateAddr),
        .updateData(alignedData), .updateMask(byteMask)
    );

    backingMemory memory (
        .clk(clk), .rst(rst),
        .memRead(memRead), .memAddr(memAddr),
        .memWrite(memWrite), .memWdata(alignedData), .memMask(byteMask),
        .memValid(memValid), .memRdata(memRdata)
    );

endmodule

// File: logic/storeAlign.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module storeAlign (
    input  logic [`ADDR_W-1:0]            addr,
    input  cachePkg::accessSize_t         size,
    input  logic [cachePkg::DATA_W-1:0]   storeData,
    input  logic [cachePkg::DATA_W-1:0]   loadWord,
    output logic [cachePkg::DATA_W-1:0]   alignedData,
    output logic [cachePkg::MASK_W-1:0]   byteMask,
    output logic [cachePkg::DATA_W-1:0]   loadResult
);
    import cachePkg::*;

    logic [OFFSET_W-1:0] byteOffset;
    logic [OFFSET_W-1:0] alignBits;
    logic [MASK_W-1:0]   sizeMask;
    logic [DATA_W-1:0]   sizeBits;

    assign byteOffset = addr[OFFSET_W-1:0];

    always_comb begin
        case (size)
            SIZE_B: begin
                sizeMask = 8'h01;
                alignBits = 3'b000;
            end
            SIZE_H: begin
                sizeMask = 8'h03;
                alignBits = 3'b001;
            end
            SIZE_W: begin
                sizeMask = 8'h0f;
                alignBits = 3'b011;
            end
            default: begin
                sizeMask = 8'hff;
                alignBits = 3'b111;
            end
        endcase
    end

    always_comb begin
        for (int b = 0; b < MASK_W; b++) begin
            sizeBits[8*b +: 8] = {8{sizeMask[b]}};
        end
    end

    // stores move up to their byte lane. Loads come down to bit zero.
    assign byteMask = sizeMask << byteOffset;
    assign alignedData = storeData << {byteOffset, 3'b000};
    assign loadResult = (loadWord >> {byteOffset, 3'b000}) & sizeBits;

    always_comb begin
        naturalAlign: assert final ($isunknown({byteOffset, size})
                                    || (byteOffset & alignBits) == '0)
            else $error("storeAlign: misaligned access at %h", addr);
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tbMemSubsystem \
    -o simMemSubsystem

./obj_dir/simMemSubsystem 2>&1 | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    echo "run.sh: simulation ok"
else
    echo "run.sh: simulation failed, see sim.log"
    exit 1
fi

// File: tb/tbMemSubsystem.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module tbMemSubsystem;
    import cachePkg::*;

    localparam logic STORE = 1'b1;
    localparam logic LOAD = 1'b0;
    localparam int MARGIN = 30;

    logic               clk;
    logic               rst;
    logic               loadReq;
    logic               storeReq;
    logic [`ADDR_W-1:0] addr;
    accessSize_t        size;
    logic [63:0]        storeData;
    logic               loadDone;
    logic               loadHit;
    logic [63:0]        loadData;
    logic               storeDone;
    logic               busy;

    // stimulus table, one entry per access.
    logic               opStore [$];
    logic [`ADDR_W-1:0] opAddr [$];
    accessSize_t        opSize [$];
    logic [63:0]        opData [$];
    logic               opHit [$];

    // reference memory as bytes, and the tag state of a 4-set, 2-way cache.
    logic [7:0]         refMem [`MEM_WORDS*8];
    logic               refValid [`SETS][2];
    logic [63:0]        refTag [`SETS][2];
    logic               refToggle [`SETS];

    integer seed;
    int cycleCount = 0;
    int cycleLimit = 0;
    int errors = 0;

    memSubsystem UUT (
        .clk(clk), .rst(rst),
        .loadReq(loadReq), .storeReq(storeReq), .addr(addr), .size(size),
        .storeData(storeData),
        .loadDone(loadDone), .loadHit(loadHit), .loadData(loadData),
        .storeDone(storeDone), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: no done pulse came back within %0d cycles", cycleLimit);
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped on timeout");
        end
    end

    task automatic check(input string name, input logic [63:0] got,
                         input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int sizeBytes(input accessSize_t s);
        case (s)
            SIZE_B: return 1;
            SIZE_H: return 2;
            SIZE_W: return 4;
            default: return 8;
        endcase
    endfunction

    task automatic addOp(input logic isStore, input logic [`ADDR_W-1:0] a,
                         input accessSize_t s, input logic expHit);
        logic [31:0] upper;
        logic [31:0] lower;
        upper = $random(seed);
        lower = $random(seed);
        opStore.push_back(isStore);
        opAddr.push_back(a);
        opSize.push_back(s);
        opData.push_back({upper, lower});
        opHit.push_back(expHit);
    endtask

    task automatic buildTable();
        // every line used below starts with a full doubleword in memory.
        addOp(STORE, 'h000, SIZE_D, 1'b0);
        addOp(STORE, 'h020, SIZE_D, 1'b0);
        addOp(STORE, 'h040, SIZE_D, 1'b0);
        addOp(STORE, 'h008, SIZE_D, 1'b0);
        addOp(STORE, 'h010, SIZE_D, 1'b0);
        addOp(STORE, 'h018, SIZE_D, 1'b0);
        addOp(LOAD,  'h008, SIZE_D, 1'b0);
        addOp(LOAD,  'h008, SIZE_D, 1'b1);
        // narrow stores merged into a cached line.
        addOp(STORE, 'h00b, SIZE_B, 1'b0);
        addOp(STORE, 'h00e, SIZE_H, 1'b0);
        addOp(LOAD,  'h00b, SIZE_B, 1'b1);
        addOp(LOAD,  'h00e, SIZE_H, 1'b1);
        addOp(LOAD,  'h00c, SIZE_W, 1'b1);
        addOp(LOAD,  'h008, SIZE_D, 1'b1);
        // the same into a line that only lives in memory.
        addOp(STORE, 'h014, SIZE_W, 1'b0);
        addOp(STORE, 'h011, SIZE_B, 1'b0);
        addOp(LOAD,  'h010, SIZE_D, 1'b0);
        addOp(LOAD,  'h012, SIZE_H, 1'b1);
        addOp(LOAD,  'h011, SIZE_B, 1'b1);
        addOp(LOAD,  'h014, SIZE_W, 1'b1);
        // three tags in set 0, so the third fill takes way 0 back.
        addOp(LOAD,  'h000, SIZE_D, 1'b0);
        addOp(LOAD,  'h020, SIZE_D, 1'b0);
        addOp(LOAD,  'h040, SIZE_D, 1'b0);
        addOp(LOAD,  'h020, SIZE_D, 1'b1);
        addOp(LOAD,  'h000, SIZE_D, 1'b0);
        addOp(STORE, 'h041, SIZE_B, 1'b0);
        addOp(STORE, 'h006, SIZE_H, 1'b0);
        addOp(LOAD,  'h040, SIZE_D, 1'b1);
        addOp(LOAD,  'h000, SIZE_D, 1'b1);
        addOp(LOAD,  'h041, SIZE_B, 1'b1);
        // stores to lines not in the cache must not allocate.
        addOp(STORE, 'h108, SIZE_D, 1'b0);
        addOp(LOAD,  'h108, SIZE_D, 1'b0);
        addOp(STORE, 'h10a, SIZE_H, 1'b0);
        addOp(LOAD,  'h108, SIZE_D, 1'b1);
        addOp(LOAD,  'h008, SIZE_D, 1'b1);
        addOp(STORE, 'h118, SIZE_W, 1'b0);
        addOp(LOAD,  'h118, SIZE_W, 1'b0);
        addOp(LOAD,  'h018, SIZE_D, 1'b0);
        addOp(LOAD,  'h01f, SIZE_B, 1'b1);
    endtask

    task automatic refStore(input logic [`ADDR_W-1:0] a, input accessSize_t s,
                            input logic [63:0] d);
        for (int i = 0; i < sizeBytes(s); i++) begin
            refMem[a + i] = d[8*i +: 8];
        end
    endtask

    function automatic logic [63:0] expectedLoad(input logic [`ADDR_W-1:0] a,
                                                 input accessSize_t s);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < sizeBytes(s); i++) begin
            value[8*i +: 8] = refMem[a + i];
        end
        return value;
    endfunction

    // set index is address bits 4..3; a miss fills the way named by the toggle.
    task automatic refLoad(input logic [`ADDR_W-1:0] a, output logic hitFlag);
        logic [1:0]  set;
        logic [63:0] tag;
        logic        way;
        set = a[4:3];
        tag = a >> 5;
        hitFlag = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (refValid[set][w] && refTag[set][w] == tag) begin
                hitFlag = 1'b1;
            end
        end
        if (!hitFlag) begin
            way = refToggle[set];
            refValid[set][way] = 1'b1;
            refTag[set][way] = tag;
            refToggle[set] = ~refToggle[set];
        end
    endtask

    task automatic applyOp(input int n);
        logic modelHit;
        logic waiting;
        int   latency;
        @(negedge clk);
        addr = opAddr[n];
        size = opSize[n];
        storeData = opData[n];
        if (opStore[n]) begin
            storeReq = 1'b1;
        end else begin
            loadReq = 1'b1;
        end
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
            @(negedge clk);
            loadReq = 1'b0;
            storeReq = 1'b0;
            waiting = !(opStore[n] ? storeDone : loadDone);
            // a load keeps the unit busy until its done pulse.
            if (waiting && !opStore[n]) begin
                check("busy", busy, 1);
            end
        end while (waiting);
        check("busy", busy, 0);
        // latency counts edges from the drive, so the accepting edge adds one.
        if (opStore[n]) begin
            check("loadDone", loadDone, 0);
            check("store latency", latency, 1);
            refStore(opAddr[n], opSize[n], opData[n]);
        end else begin
            refLoad(opAddr[n], modelHit);
            check("reference hit", modelHit, opHit[n]);
            check("storeDone", storeDone, 0);
            check("loadHit", loadHit, opHit[n]);
            check("loadData", loadData, expectedLoad(opAddr[n], opSize[n]));
            check("load latency", latency, opHit[n] ? 2 : `MEM_LATENCY + 3);
        end
    endtask

    initial begin
        seed = 32'h538ca56a;
        rst = 1'b1;
        loadReq = 1'b0;
        storeReq = 1'b0;
        addr = '0;
        size = SIZE_D;
        storeData = '0;
        for (int s = 0; s < `SETS; s++) begin
            refValid[s][0] = 1'b0;
            refValid[s][1] = 1'b0;
            refToggle[s] = 1'b0;
        end
        buildTable();
        cycleLimit = opStore.size() * (`MEM_LATENCY + 4) + 2 + MARGIN;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("busy", busy, 0);
        check("loadDone", loadDone, 0);
        check("storeDone", storeDone, 0);
        for (int n = 0; n < opStore.size(); n++) begin
            applyOp(n);
        end
        @(negedge clk);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
